// File: rtl/sifhGeometryPkg.sv
package sifhGeometryPkg;

    // ------------------------------
    // acquisition shape.
    // ------------------------------
    localparam int sampleWidth     = 10;  // raw sample bits.
    localparam int pixelsPerRam    = 3;
    localparam int samplesPerPixel = 2;   // consecutive within one frame.
    localparam int framesPerAcq    = 2;

    // position counter widths.
    localparam int pixelIndexWidth  = 2;
    localparam int sampleIndexWidth = 1;  // counts samplesPerPixel.
    localparam int frameIndexWidth  = 1;  // counts framesPerAcq.

endpackage

// File: rtl/sifhResultPkg.sv
package sifhResultPkg;

    // ------------------------------
    // result word shape.
    // ------------------------------
    localparam int sumWidth  = 12;    // holds 4 full-scale samples.
    localparam int meanShift = 2;     // sum of 4 down to a mean.
    localparam int fullScale = 1023;  // saturated sample.

    localparam int resultWidth = sifhGeometryPkg::sampleWidth * sifhGeometryPkg::pixelsPerRam;

    // output handshake states.
    localparam int stateWidth = 2;
    localparam logic [stateWidth-1:0] stIdle    = 2'd0;
    localparam logic [stateWidth-1:0] stWaitSum = 2'd1;  // acquisition closed and sums pending.
    localparam logic [stateWidth-1:0] stRequest = 2'd2;
    localparam logic [stateWidth-1:0] stRelease = 2'd3;

endpackage

// File: rtl/sampleStreamIf.sv
`timescale 1ns/1ps

interface sampleStreamIf;
    import sifhGeometryPkg::*;

    logic                       valid;        // one cycle per accepted sample.
    logic [sampleWidth-1:0]     data;
    logic [pixelIndexWidth-1:0] pixelIndex;
    logic                       firstSample;  // opens an acquisition.
    logic                       lastSample;   // closes it.

    // sequencer side.
    modport source (
        output valid, data, pixelIndex, firstSample, lastSample
    );

    // builder side.
    modport sink (
        input valid, data, pixelIndex, firstSample, lastSample
    );

endinterface

// File: rtl/sampleSequencer.sv
`timescale 1ns/1ps

module sampleSequencer (
    input  logic                                    clk,
    input  logic                                    reset,
    input  logic                                    wrEn,
    input  logic [sifhGeometryPkg::sampleWidth-1:0] data,
    input  logic                                    busy,
    output logic                                    acqFull,
    sampleStreamIf.source                           stream
);
    import sifhGeometryPkg::*;

    logic [sampleIndexWidth-1:0] sampleCnt;
    logic [pixelIndexWidth-1:0]  pixelCnt;
    logic [frameIndexWidth-1:0]  frameCnt;
    logic                        accept;
    logic                        lastInPixel;
    logic                        lastPixel;
    logic                        lastFrame;
    logic                        atStart;

    assign accept      = wrEn && !busy;  // nothing is taken while a result is pending.
    assign lastInPixel = (sampleCnt == sampleIndexWidth'(samplesPerPixel - 1));
    assign lastPixel   = (pixelCnt == pixelIndexWidth'(pixelsPerRam - 1));
    assign lastFrame   = (frameCnt == frameIndexWidth'(framesPerAcq - 1));
    assign atStart     = (sampleCnt == '0) && (pixelCnt == '0) && (frameCnt == '0);

    // tells the merger at once, so busy is set on this same edge.
    assign acqFull = accept && lastInPixel && lastPixel && lastFrame;

    // ------------------------------
    // position counters.
    // ------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            sampleCnt <= '0;
            pixelCnt  <= '0;
            frameCnt  <= '0;
        end else if (accept) begin
            if (lastInPixel) begin
                sampleCnt <= '0;
                if (lastPixel) begin
                    pixelCnt <= '0;
                    frameCnt <= lastFrame ? '0 : frameCnt + 1'b1;
                end else begin
                    pixelCnt <= pixelCnt + 1'b1;
                end
            end else begin
                sampleCnt <= sampleCnt + 1'b1;
            end
        end
    end

    // ------------------------------
    // registered stream.
    // ------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            stream.valid <= 1'b0;
        end else begin
            stream.valid <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            stream.data        <= data;
            stream.pixelIndex  <= pixelCnt;
            stream.firstSample <= atStart;
            stream.lastSample  <= acqFull;
        end
    end

endmodule

// File: rtl/sumBuilder.sv
`timescale 1ns/1ps

module sumBuilder (
    input  logic                                                              clk,
    input  logic                                                              reset,
    sampleStreamIf.sink                                                       stream,
    output logic [sifhGeometryPkg::pixelsPerRam*sifhResultPkg::sumWidth-1:0] sums,
    output logic                                                              sumDone
);
    import sifhGeometryPkg::*;
    import sifhResultPkg::*;

    logic [sumWidth-1:0] acc [pixelsPerRam];
    logic [sumWidth-1:0] sample;

    assign sample = {{(sumWidth - sampleWidth){1'b0}}, stream.data};

    // first sample of an acquisition restarts every pixel.
    always_ff @(posedge clk) begin
        if (stream.valid) begin
            for (int i = 0; i < pixelsPerRam; i++) begin
                if (stream.pixelIndex == pixelIndexWidth'(i)) begin
                    acc[i] <= stream.firstSample ? sample : acc[i] + sample;
                end else if (stream.firstSample) begin
                    acc[i] <= '0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            sumDone <= 1'b0;
        end else begin
            sumDone <= stream.valid && stream.lastSample;  // sums final next cycle.
        end
    end

    // pixel 0 in the low bits.
    always_comb begin
        for (int i = 0; i < pixelsPerRam; i++) begin
            sums[i*sumWidth +: sumWidth] = acc[i];
        end
    end

endmodule

// File: rtl/peakTracker.sv
`timescale 1ns/1ps

module peakTracker (
    input  logic                                                                clk,
    input  logic                                                                reset,
    sampleStreamIf.sink                                                         stream,
    output logic [sifhGeometryPkg::pixelsPerRam*sifhGeometryPkg::sampleWidth-1:0] peaks,
    output logic                                                                peakDone
);
    import sifhGeometryPkg::*;

    logic [sampleWidth-1:0]  peak [pixelsPerRam];
    logic [pixelsPerRam-1:0] seen;  // pixel already has a sample this acquisition.

    always_ff @(posedge clk) begin
        if (reset) begin
            seen <= '0;
        end else if (stream.valid) begin
            for (int i = 0; i < pixelsPerRam; i++) begin
                if (stream.pixelIndex == pixelIndexWidth'(i)) begin
                    seen[i] <= 1'b1;
                end else if (stream.firstSample) begin
                    seen[i] <= 1'b0;
                end
            end
        end
    end

    // reload on the pixel's first sample, then keep the larger one.
    always_ff @(posedge clk) begin
        if (stream.valid) begin
            for (int i = 0; i < pixelsPerRam; i++) begin
                if (stream.pixelIndex == pixelIndexWidth'(i)) begin
                    if (stream.firstSample || !seen[i] || stream.data > peak[i]) begin
                        peak[i] <= stream.data;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            peakDone <= 1'b0;
        end else begin
            peakDone <= stream.valid && stream.lastSample;
        end
    end

    always_comb begin
        for (int i = 0; i < pixelsPerRam; i++) begin
            peaks[i*sampleWidth +: sampleWidth] = peak[i];
        end
    end

endmodule

// File: rtl/pixelMerger.sv
`timescale 1ns/1ps

module pixelMerger (
    input  logic                                                              clk,
    input  logic                                                              reset,
    input  logic [sifhGeometryPkg::pixelsPerRam*sifhResultPkg::sumWidth-1:0] sums,
    input  logic                                                              sumDone,
    input  logic [sifhGeometryPkg::pixelsPerRam*sifhGeometryPkg::sampleWidth-1:0] peaks,
    input  logic                                                              acqFull,
    input  logic                                                              resultAck,
    output logic                                                              busy,
    output logic [sifhResultPkg::resultWidth-1:0]                             result,
    output logic                                                              resultReq
);
    import sifhGeometryPkg::*;
    import sifhResultPkg::*;

    logic [stateWidth-1:0]  state;
    logic [sumWidth-1:0]    shifted [pixelsPerRam];
    logic [sampleWidth-1:0] pixelPeak [pixelsPerRam];
    logic [resultWidth-1:0] words;

    // ------------------------------
    // per-pixel word.
    // ------------------------------
    always_comb begin
        for (int i = 0; i < pixelsPerRam; i++) begin
            shifted[i]   = sums[i*sumWidth +: sumWidth] >> meanShift;
            pixelPeak[i] = peaks[i*sampleWidth +: sampleWidth];
            if (pixelPeak[i] == sampleWidth'(fullScale)) begin
                words[i*sampleWidth +: sampleWidth] = sampleWidth'(fullScale);  // saturated.
            end else begin
                words[i*sampleWidth +: sampleWidth] = shifted[i][sampleWidth-1:0];
            end
        end
    end

    // held from here until the handshake is released.
    always_ff @(posedge clk) begin
        if (state == stWaitSum && sumDone) begin
            result <= words;
        end
    end

    // ------------------------------
    // handshake FSM.
    // ------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            state <= stIdle;
        end else begin
            case (state)
                stIdle: begin
                    if (acqFull) begin
                        state <= stWaitSum;  // last sample just taken.
                    end
                end
                stWaitSum: begin
                    if (sumDone) begin
                        state <= stRequest;
                    end
                end
                stRequest: begin
                    if (resultAck) begin
                        state <= stRelease;
                    end
                end
                stRelease: begin
                    if (!resultAck) begin
                        state <= stIdle;
                    end
                end
                default: state <= stIdle;
            endcase
        end
    end

    assign busy      = (state != stIdle);
    assign resultReq = (state == stRequest);  // drops the cycle after ack is seen.

endmodule

// File: rtl/hisBuilderTop.sv
`timescale 1ns/1ps

module hisBuilderTop (
    input  logic                                    clk,
    input  logic                                    reset,
    input  logic                                    wrEn,
    input  logic [sifhGeometryPkg::sampleWidth-1:0] data,
    input  logic                                    resultAck,
    output logic                                    busy,
    output logic                                    resultReq,
    output logic [sifhResultPkg::resultWidth-1:0]   result
);

    logic [sifhGeometryPkg::pixelsPerRam*sifhResultPkg::sumWidth-1:0]       sums;
    logic [sifhGeometryPkg::pixelsPerRam*sifhGeometryPkg::sampleWidth-1:0] peaks;
    logic                                                                   sumDone;
    logic                                                                   acqFull;

    sampleStreamIf stream ();

    sampleSequencer sequencerU0 (
        .clk     (clk),
        .reset   (reset),
        .wrEn    (wrEn),
        .data    (data),
        .busy    (busy),
        .acqFull (acqFull),
        .stream  (stream.source)
    );

    sumBuilder sumBuilderU0 (
        .clk     (clk),
        .reset   (reset),
        .stream  (stream.sink),
        .sums    (sums),
        .sumDone (sumDone)
    );

    // peaks settle in the same cycle as the sums, so sumDone covers both.
    peakTracker peakTrackerU0 (
        .clk      (clk),
        .reset    (reset),
        .stream   (stream.sink),
        .peaks    (peaks),
        .peakDone ()
    );

    pixelMerger mergerU0 (
        .clk       (clk),
        .reset     (reset),
        .sums      (sums),
        .sumDone   (sumDone),
        .peaks     (peaks),
        .acqFull   (acqFull),
        .resultAck (resultAck),
        .busy      (busy),
        .result    (result),
        .resultReq (resultReq)
    );

endmodule

// File: bench/hisBuilderTB.sv
`timescale 1ns/1ps

module hisBuilderTB;
    import sifhGeometryPkg::*;
    import sifhResultPkg::*;

    localparam int acqSamples = samplesPerPixel * pixelsPerRam * framesPerAcq;
    localparam int numRows    = 6;
    localparam int waitLimit  = 40;  // cycles per wait.

    logic                   clk;
    logic                   reset;
    logic                   wrEn;
    logic [sampleWidth-1:0] data;
    logic                   resultAck;
    logic                   busy;
    logic                   resultReq;
    logic [resultWidth-1:0] result;

    // ------------------------------
    // stimulus table.
    // ------------------------------
    string                  testName      [numRows];
    logic [sampleWidth-1:0] sampleTab     [numRows][acqSamples];
    logic [acqSamples-1:0]  gapMask       [numRows];  // a set bit k idles one cycle before sample k.
    int                     ackDelay      [numRows];
    bit                     junkWhileBusy [numRows];  // keep writing while a result is pending.

    integer                 seed;
    logic [resultWidth-1:0] expected;

    hisBuilderTop UUT (
        .clk       (clk),
        .reset     (reset),
        .wrEn      (wrEn),
        .data      (data),
        .resultAck (resultAck),
        .busy      (busy),
        .resultReq (resultReq),
        .result    (result)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic failRun(input string why);
        $display("%s", why);
        $display("Checks failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic checkResult(input string name, input logic [resultWidth-1:0] exp,
                               input logic [resultWidth-1:0] act);
        if (act !== exp) begin
            failRun($sformatf("CHECK FAILED %s expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic checkFlag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            failRun($sformatf("CHECK FAILED %s expected %b actual %b", name, exp, act));
        end
    endtask

    task automatic waitReq(input logic level, input string name);
        int cycles;
        cycles = 0;
        while (resultReq !== level) begin
            @(posedge clk);
            #1;
            cycles++;
            if (cycles > waitLimit) begin
                failRun($sformatf("%s: resultReq never went to %b", name, level));
            end
        end
    endtask

    task automatic waitBusyLow(input string name);
        int cycles;
        cycles = 0;
        while (busy !== 1'b0) begin
            @(posedge clk);
            #1;
            cycles++;
            if (cycles > waitLimit) begin
                failRun($sformatf("%s: busy stayed high after the handshake", name));
            end
        end
    endtask

    // mean of each pixel's samples, or full scale if any of them saturates.
    function automatic logic [resultWidth-1:0] expectedResult(input int row);
        logic [resultWidth-1:0] words;
        int                     sum;
        bit                     sat;
        words = '0;
        for (int p = 0; p < pixelsPerRam; p++) begin
            sum = 0;
            sat = 1'b0;
            for (int k = 0; k < acqSamples; k++) begin
                if ((k / samplesPerPixel) % pixelsPerRam == p) begin
                    sum += sampleTab[row][k];
                    sat |= (sampleTab[row][k] == 10'd1023);
                end
            end
            words[p*sampleWidth +: sampleWidth] =
                sat ? 10'd1023 : sampleWidth'(sum / (samplesPerPixel * framesPerAcq));
        end
        return words;
    endfunction

    task automatic buildTable();
        testName[0] = "plainMean";
        sampleTab[0] = '{10'd100, 10'd104, 10'd7, 10'd9, 10'd500, 10'd501,
                         10'd102, 10'd103, 10'd8, 10'd6, 10'd502, 10'd503};
        testName[1] = "saturation";
        sampleTab[1] = '{10'd10, 10'd20, 10'd1023, 10'd5, 10'd300, 10'd301,
                         10'd30, 10'd40, 10'd6, 10'd7, 10'd302, 10'd303};
        testName[2] = "gapsSameAsPlain";
        sampleTab[2] = sampleTab[0];
        testName[3] = "backPressure";
        testName[4] = "backToBack";
        testName[5] = "randomGaps";
        for (int r = 3; r < numRows; r++) begin
            for (int k = 0; k < acqSamples; k++) begin
                sampleTab[r][k] = sampleWidth'($random(seed));
            end
        end
        gapMask       = '{12'h000, 12'h000, 12'b1001_0110_0101, 12'h000, 12'h000, 12'h3c3};
        ackDelay      = '{0, 1, 0, 6, 0, 2};
        junkWhileBusy = '{0, 0, 0, 1, 0, 0};
    endtask

    task automatic applyRow(input int row);
        for (int k = 0; k < acqSamples; k++) begin
            if (gapMask[row][k]) begin
                wrEn = 1'b0;
                @(posedge clk);
                #1;
            end
            wrEn = 1'b1;
            data = sampleTab[row][k];
            @(posedge clk);
            #1;
        end
        wrEn = 1'b0;
    endtask

    initial begin
        seed      = 32'h288d706c;
        reset     = 1'b1;
        wrEn      = 1'b0;
        data      = '0;
        resultAck = 1'b0;
        buildTable();
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;
        checkFlag("resetReq", 1'b0, resultReq);
        checkFlag("resetBusy", 1'b0, busy);

        for (int r = 0; r < numRows; r++) begin
            expected = expectedResult(r);
            applyRow(r);
            checkFlag({testName[r], " busyAfterLast"}, 1'b1, busy);
            if (junkWhileBusy[r]) begin
                wrEn = 1'b1;
                data = 10'd1023;  // would saturate the next row if taken.
            end
            waitReq(1'b1, testName[r]);
            checkResult(testName[r], expected, result);
            repeat (ackDelay[r]) begin
                @(posedge clk);
                #1;
                checkFlag({testName[r], " reqHeld"}, 1'b1, resultReq);
                checkResult({testName[r], " resultHeld"}, expected, result);
            end
            resultAck = 1'b1;
            waitReq(1'b0, testName[r]);
            checkFlag({testName[r], " busyInRelease"}, 1'b1, busy);
            resultAck = 1'b0;
            wrEn      = 1'b0;
            waitBusyLow(testName[r]);
            checkFlag({testName[r], " reqAfterRelease"}, 1'b0, resultReq);
        end

        $display("All checks passed");
        $finish;
    end

endmodule

// File: files.f
rtl/sifhGeometryPkg.sv
rtl/sifhResultPkg.sv
rtl/sampleStreamIf.sv
rtl/sampleSequencer.sv
rtl/sumBuilder.sv
rtl/peakTracker.sv
rtl/pixelMerger.sv
rtl/hisBuilderTop.sv
bench/hisBuilderTB.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
{ verilator --binary --timing -Wno-fatal -f files.f --top-module hisBuilderTB -Mdir obj_dir &&
  ./obj_dir/VhisBuilderTB; } > sim.log 2>&1 || echo "Checks failed" >> sim.log
cat sim.log
grep -q "Checks failed" sim.log && exit 1 || exit 0
